// File: bus_pkg.sv
// bus package: NMI and APB4 request/response structs and bus widths
`default_nettype none

package bus_pkg;

  localparam int DATA_W = 32;
  // byte lanes per data word
  localparam int STRB_W = DATA_W / 8;
  // offset width inside one peripheral slot
  localparam int APB_AW = 12;

  typedef logic [DATA_W-1:0] word_t;

  // cpu side request, wstrb of zero is a read
  typedef struct packed {
    logic              valid;
    word_t             addr;
    word_t             wdata;
    logic [STRB_W-1:0] wstrb;
  } nmi_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } nmi_rsp_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    word_t             pwdata;
    logic [STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: mmap_pkg.sv
// memory map package: slot numbers, register offsets and bit positions
`default_nettype none

package mmap_pkg;

  // address bits 15:12 pick the slot
  localparam int SLOT_LSB  = 12;
  localparam int SLOT_W    = 4;
  localparam int SLOT_TMR  = 0;
  localparam int SLOT_CRC  = 1;
  localparam int NUM_SLOTS = 2;

  // timer registers
  localparam logic [bus_pkg::APB_AW-1:0] TMR_CTRL = 12'h000;
  localparam logic [bus_pkg::APB_AW-1:0] TMR_PSCR = 12'h004;
  localparam logic [bus_pkg::APB_AW-1:0] TMR_CMP  = 12'h008;
  localparam logic [bus_pkg::APB_AW-1:0] TMR_CNT  = 12'h00C;
  localparam logic [bus_pkg::APB_AW-1:0] TMR_STAT = 12'h010;
  localparam logic [bus_pkg::APB_AW-1:0] TMR_CAP  = 12'h014;

  localparam int TMR_CTRL_EN_BIT    = 0;
  localparam int TMR_CTRL_IE_BIT    = 1;
  localparam int TMR_STAT_MATCH_BIT = 0;

  // crc registers
  localparam logic [bus_pkg::APB_AW-1:0] CRC_CTRL = 12'h000;
  localparam logic [bus_pkg::APB_AW-1:0] CRC_DATA = 12'h004;
  localparam logic [bus_pkg::APB_AW-1:0] CRC_RES  = 12'h008;

  localparam int CRC_CTRL_INIT_BIT = 0;
  // one byte per data write
  localparam int CRC_BYTE_W = 8;

  // reflected IEEE 802.3 polynomial
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// File: crc32_core.sv
// byte-serial reflected CRC-32 engine, one byte per cycle
`default_nettype none

module crc32_core (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            init_i,
  input  logic                            byte_valid_i,
  input  logic [mmap_pkg::CRC_BYTE_W-1:0] byte_i,
  output bus_pkg::word_t                  crc_state_o
);

  bus_pkg::word_t state_q;
  bus_pkg::word_t next_state;

  // eight lsb-first shift steps of the reflected polynomial
  always_comb begin
    bus_pkg::word_t c;
    c = state_q ^ bus_pkg::word_t'(byte_i);
    for (int k = 0; k < mmap_pkg::CRC_BYTE_W; k++) begin
      if (c[0]) c = (c >> 1) ^ mmap_pkg::CRC_POLY;
      else c = c >> 1;
    end
    next_state = c;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mmap_pkg::CRC_INIT;
    end else if (init_i) begin
      state_q <= mmap_pkg::CRC_INIT;
    end else if (byte_valid_i) begin
      state_q <= next_state;
    end
  end

  assign crc_state_o = state_q;

endmodule

`default_nettype wire

// File: apb4_crc_regs.sv
// CRC register block that turns APB writes into engine commands and returns the result
`default_nettype none

module apb4_crc_regs (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  bus_pkg::apb_req_t               apb_req_i,
  output bus_pkg::apb_rsp_t               apb_rsp_o,
  output logic                            init_o,
  output logic                            byte_valid_o,
  output logic [mmap_pkg::CRC_BYTE_W-1:0] byte_o,
  input  bus_pkg::word_t                  crc_state_i
);

  logic                            wr;
  logic                            init_wr;
  logic                            data_wr;
  logic                            init_q;
  logic                            byte_valid_q;
  logic [mmap_pkg::CRC_BYTE_W-1:0] byte_q;
  bus_pkg::word_t                  rdata;

  assign wr = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;

  assign init_wr = wr && apb_req_i.paddr == mmap_pkg::CRC_CTRL && apb_req_i.pstrb[0] &&
                   apb_req_i.pwdata[mmap_pkg::CRC_CTRL_INIT_BIT];

  // data byte lives in lane 0
  assign data_wr = wr && apb_req_i.paddr == mmap_pkg::CRC_DATA && apb_req_i.pstrb[0];

  // one command pulse per access phase
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_q       <= 1'b0;
      byte_valid_q <= 1'b0;
    end else begin
      init_q       <= init_wr;
      byte_valid_q <= data_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_wr) byte_q <= apb_req_i.pwdata[mmap_pkg::CRC_BYTE_W-1:0];
  end

  assign init_o       = init_q;
  assign byte_valid_o = byte_valid_q;
  assign byte_o       = byte_q;

  // final xor folded into the read path
  always_comb begin
    rdata = '0;
    if (apb_req_i.paddr == mmap_pkg::CRC_RES) rdata = ~crc_state_i;
  end

  assign apb_rsp_o.pready  = apb_req_i.psel;
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = 1'b0;

  // commands are exclusive and never repeat in the next cycle
  a_cmd_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (init_o || byte_valid_o) |->
      !(init_o && byte_valid_o) && !$past(init_o || byte_valid_o));

endmodule

`default_nettype wire

// File: apb4_tmr.sv
// APB4 timer: prescaled counter, compare match interrupt and input capture
`default_nettype none

module apb4_tmr (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  bus_pkg::apb_req_t apb_req_i,
  output bus_pkg::apb_rsp_t apb_rsp_o,
  input  logic              tmr_capch_i,
  output logic              tmr_irq_o
);

  logic [1:0]     ctrl_q;
  bus_pkg::word_t pscr_q;
  bus_pkg::word_t cmp_q;
  bus_pkg::word_t cnt_q;
  bus_pkg::word_t psc_q;
  bus_pkg::word_t cap_q;
  logic           flag_q;
  logic [1:0]     cap_sync_q;
  logic           cap_prev_q;
  logic           wr;
  logic           tick;
  logic           cap_rise;
  bus_pkg::word_t rdata;

  // byte lane merge of a write into a register
  function automatic bus_pkg::word_t merge(bus_pkg::word_t old_v, bus_pkg::word_t new_v,
                                           logic [bus_pkg::STRB_W-1:0] strb);
    bus_pkg::word_t res;
    res = old_v;
    for (int b = 0; b < bus_pkg::STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  assign wr       = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
  assign tick     = ctrl_q[mmap_pkg::TMR_CTRL_EN_BIT] && (psc_q == pscr_q);
  assign cap_rise = cap_sync_q[1] && !cap_prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q     <= '0;
      pscr_q     <= '0;
      cmp_q      <= '0;
      cnt_q      <= '0;
      psc_q      <= '0;
      cap_q      <= '0;
      flag_q     <= 1'b0;
      cap_sync_q <= '0;
      cap_prev_q <= 1'b0;
    end else begin
      cap_sync_q <= {cap_sync_q[0], tmr_capch_i};
      cap_prev_q <= cap_sync_q[1];
      if (cap_rise) cap_q <= cnt_q;

      // prescaler runs only while enabled
      if (!ctrl_q[mmap_pkg::TMR_CTRL_EN_BIT] || tick) psc_q <= '0;
      else psc_q <= psc_q + 1'b1;

      if (wr && apb_req_i.paddr == mmap_pkg::TMR_STAT && apb_req_i.pstrb[0] &&
          apb_req_i.pwdata[mmap_pkg::TMR_STAT_MATCH_BIT]) begin
        flag_q <= 1'b0;
      end

      if (wr && apb_req_i.paddr == mmap_pkg::TMR_CNT) begin
        cnt_q <= merge(cnt_q, apb_req_i.pwdata, apb_req_i.pstrb);
      end else if (tick) begin
        if (cnt_q == cmp_q) begin
          cnt_q  <= '0;
          flag_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end

      if (wr && apb_req_i.paddr == mmap_pkg::TMR_CTRL && apb_req_i.pstrb[0]) begin
        ctrl_q <= apb_req_i.pwdata[1:0];
      end
      if (wr && apb_req_i.paddr == mmap_pkg::TMR_PSCR) begin
        pscr_q <= merge(pscr_q, apb_req_i.pwdata, apb_req_i.pstrb);
      end
      if (wr && apb_req_i.paddr == mmap_pkg::TMR_CMP) begin
        cmp_q <= merge(cmp_q, apb_req_i.pwdata, apb_req_i.pstrb);
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (apb_req_i.paddr)
      mmap_pkg::TMR_CTRL: rdata[1:0] = ctrl_q;
      mmap_pkg::TMR_PSCR: rdata = pscr_q;
      mmap_pkg::TMR_CMP:  rdata = cmp_q;
      mmap_pkg::TMR_CNT:  rdata = cnt_q;
      mmap_pkg::TMR_STAT: rdata[mmap_pkg::TMR_STAT_MATCH_BIT] = flag_q;
      mmap_pkg::TMR_CAP:  rdata = cap_q;
      default:            rdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = apb_req_i.psel;
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = 1'b0;

  assign tmr_irq_o = flag_q && ctrl_q[mmap_pkg::TMR_CTRL_IE_BIT];

  // zero wait states, relies on the bridge never raising penable alone
  a_pready_access : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> apb_rsp_o.pready);

endmodule

`default_nettype wire

// File: nmi2apb.sv
// NMI to APB4 bridge that decodes the slot and sequences setup and access phases
`default_nettype none

module nmi2apb (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  bus_pkg::nmi_req_t  nmi_req_i,
  output bus_pkg::nmi_rsp_t  nmi_rsp_o,
  output bus_pkg::apb_req_t  apb_req_o [mmap_pkg::NUM_SLOTS],
  input  bus_pkg::apb_rsp_t  apb_rsp_i [mmap_pkg::NUM_SLOTS]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e                         state_q;
  bus_pkg::word_t                 addr_q;
  bus_pkg::word_t                 wdata_q;
  logic [bus_pkg::STRB_W-1:0]     wstrb_q;
  logic [mmap_pkg::SLOT_W-1:0]    slot;
  logic                           hit;
  logic [mmap_pkg::NUM_SLOTS-1:0] psel_vec;
  logic [mmap_pkg::NUM_SLOTS-1:0] penable_vec;
  logic                           sel_pready;
  bus_pkg::word_t                 sel_prdata;
  logic                           ready_q;
  bus_pkg::word_t                 rdata_q;

  assign slot = addr_q[mmap_pkg::SLOT_LSB +: mmap_pkg::SLOT_W];
  assign hit  = slot < mmap_pkg::SLOT_W'(mmap_pkg::NUM_SLOTS);

  // only the addressed slot gets psel
  always_comb begin
    for (int i = 0; i < mmap_pkg::NUM_SLOTS; i++) begin
      psel_vec[i]            = (state_q != ST_IDLE) && hit && (slot == mmap_pkg::SLOT_W'(i));
      penable_vec[i]         = psel_vec[i] && (state_q == ST_ACCESS);
      apb_req_o[i].psel      = psel_vec[i];
      apb_req_o[i].penable   = penable_vec[i];
      apb_req_o[i].pwrite    = |wstrb_q;
      apb_req_o[i].paddr     = addr_q[bus_pkg::APB_AW-1:0];
      apb_req_o[i].pwdata    = wdata_q;
      apb_req_o[i].pstrb     = wstrb_q;
    end
  end

  // unmapped slot completes at once and reads zero
  always_comb begin
    sel_pready = !hit;
    sel_prdata = '0;
    for (int i = 0; i < mmap_pkg::NUM_SLOTS; i++) begin
      if (hit && slot == mmap_pkg::SLOT_W'(i)) begin
        sel_pready = apb_rsp_i[i].pready;
        sel_prdata = apb_rsp_i[i].prdata;
      end
    end
  end

  // ready registered on the third edge after valid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (nmi_req_i.valid) state_q <= ST_SETUP;
        end
        ST_SETUP: begin
          state_q <= ST_ACCESS;
        end
        ST_ACCESS: begin
          if (sel_pready) begin
            state_q <= ST_IDLE;
            ready_q <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request and read data payload
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && nmi_req_i.valid) begin
      addr_q  <= nmi_req_i.addr;
      wdata_q <= nmi_req_i.wdata;
      wstrb_q <= nmi_req_i.wstrb;
    end
    if (state_q == ST_ACCESS && sel_pready) rdata_q <= sel_prdata;
  end

  assign nmi_rsp_o.ready = ready_q;
  assign nmi_rsp_o.rdata = rdata_q;

  // access phase only after a setup cycle on the same slot
  a_penable_psel : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (penable_vec & ~(psel_vec & $past(psel_vec))) == '0);

  // psel never moves to another slot without an idle cycle between
  a_psel_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(psel_vec) &&
    (psel_vec == '0 || $past(psel_vec) == '0 || psel_vec == $past(psel_vec)));

  // the cpu may not see two back to back completions
  a_ready_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nmi_rsp_o.ready |=> !nmi_rsp_o.ready);

endmodule

`default_nettype wire

// File: ip_apb_wrapper.sv
// APB peripheral island top: bridge, timer and CRC unit with the timer interrupt
`default_nettype none

module ip_apb_wrapper (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  bus_pkg::nmi_req_t nmi_req_i,
  output bus_pkg::nmi_rsp_t nmi_rsp_o,
  input  logic              tmr_capch_i,
  output logic              tmr_irq_o
);

  bus_pkg::apb_req_t               apb_req [mmap_pkg::NUM_SLOTS];
  bus_pkg::apb_rsp_t               apb_rsp [mmap_pkg::NUM_SLOTS];

  // crc register block to engine
  logic                            crc_init;
  logic                            crc_byte_valid;
  logic [mmap_pkg::CRC_BYTE_W-1:0] crc_byte;
  bus_pkg::word_t                  crc_state;

  nmi2apb u_nmi2apb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .nmi_req_i (nmi_req_i),
    .nmi_rsp_o (nmi_rsp_o),
    .apb_req_o (apb_req),
    .apb_rsp_i (apb_rsp)
  );

  apb4_tmr u_apb4_tmr (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .apb_req_i   (apb_req[mmap_pkg::SLOT_TMR]),
    .apb_rsp_o   (apb_rsp[mmap_pkg::SLOT_TMR]),
    .tmr_capch_i (tmr_capch_i),
    .tmr_irq_o   (tmr_irq_o)
  );

  apb4_crc_regs u_apb4_crc_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .apb_req_i    (apb_req[mmap_pkg::SLOT_CRC]),
    .apb_rsp_o    (apb_rsp[mmap_pkg::SLOT_CRC]),
    .init_o       (crc_init),
    .byte_valid_o (crc_byte_valid),
    .byte_o       (crc_byte),
    .crc_state_i  (crc_state)
  );

  crc32_core u_crc32_core (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .init_i       (crc_init),
    .byte_valid_i (crc_byte_valid),
    .byte_i       (crc_byte),
    .crc_state_o  (crc_state)
  );

endmodule

`default_nettype wire

// File: tb_ip_apb_wrapper.sv
// testbench for the APB peripheral island: bus timing, registers, CRC and timer capture
`default_nettype none

module tb_ip_apb_wrapper;

  localparam int XFER_EDGES   = 3;
  localparam int XFER_TIMEOUT = 20;
  localparam int IRQ_TIMEOUT  = 200;

  // one entry per issued transfer, popped when its ready arrives
  typedef struct packed {
    logic           is_read;
    bus_pkg::word_t data;
  } expect_t;

  logic                       clk;
  logic                       rst_n;
  bus_pkg::nmi_req_t          nmi_req;
  bus_pkg::nmi_rsp_t          nmi_rsp;
  logic                       tmr_capch;
  logic                       tmr_irq;

  expect_t                    exp_q[$];
  string                      msg_q[$];
  expect_t                    mon_exp;
  string                      mon_msg;
  int                         data_errs;
  int                         irq_errs;
  int                         lat_errs;
  int                         stray_errs;
  int                         other_errs;
  bus_pkg::word_t             pscr_sh;
  bus_pkg::word_t             cmp_sh;
  bus_pkg::word_t             val;
  logic [bus_pkg::STRB_W-1:0] strb;
  logic [7:0]                 bytes_q[$];
  string                      check_str;
  int                         n;
  int                         cycles;

  ip_apb_wrapper uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .nmi_req_i   (nmi_req),
    .nmi_rsp_o   (nmi_rsp),
    .tmr_capch_i (tmr_capch),
    .tmr_irq_o   (tmr_irq)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // bitwise reflected CRC-32 (IEEE 802.3) with final inversion
  function automatic bus_pkg::word_t crc32_ref(input logic [7:0] data_q[$]);
    bus_pkg::word_t crc;
    logic           fb;
    crc = 32'hFFFF_FFFF;
    foreach (data_q[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ data_q[i][b];
        crc = crc >> 1;
        if (fb) crc = crc ^ 32'hEDB8_8320;
      end
    end
    return ~crc;
  endfunction

  function automatic bus_pkg::word_t apply_strobe(input bus_pkg::word_t old_v,
                                                  input bus_pkg::word_t new_v,
                                                  input logic [bus_pkg::STRB_W-1:0] s);
    bus_pkg::word_t mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic bus_pkg::word_t slot_addr(input int slot,
                                               input logic [bus_pkg::APB_AW-1:0] off);
    return (bus_pkg::word_t'(slot) << mmap_pkg::SLOT_LSB) | bus_pkg::word_t'(off);
  endfunction

  function automatic bus_pkg::word_t tmr_addr(input logic [bus_pkg::APB_AW-1:0] off);
    return slot_addr(mmap_pkg::SLOT_TMR, off);
  endfunction

  function automatic bus_pkg::word_t crc_addr(input logic [bus_pkg::APB_AW-1:0] off);
    return slot_addr(mmap_pkg::SLOT_CRC, off);
  endfunction

  task automatic check_word(input bus_pkg::word_t got, input bus_pkg::word_t expected,
                            input string msg);
    if (got !== expected) begin
      data_errs++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, expected);
    end
  endtask

  task automatic check_irq(input logic got, input logic expected, input string msg);
    if (got !== expected) begin
      irq_errs++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, expected);
    end
  endtask

  task automatic check_latency(input int edges, input string msg);
    if (edges != XFER_EDGES) begin
      lat_errs++;
      $display("Mismatch at %0t: %s ready after %0d edges expected %0d",
               $time, msg, edges, XFER_EDGES);
    end
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) begin
      @(posedge clk);
      #10;
    end
  endtask

  // drive one request and count edges up to ready
  task automatic run_xfer(input bus_pkg::word_t addr, input bus_pkg::word_t wdata,
                          input logic [bus_pkg::STRB_W-1:0] wstrb, input string msg);
    int   edges;
    logic done;
    nmi_req.valid = 1'b1;
    nmi_req.addr  = addr;
    nmi_req.wdata = wdata;
    nmi_req.wstrb = wstrb;
    edges = 0;
    done  = 1'b0;
    while (!done && edges < XFER_TIMEOUT) begin
      @(posedge clk);
      #10;
      edges++;
      done = nmi_rsp.ready;
    end
    nmi_req.valid = 1'b0;
    if (!done) begin
      other_errs++;
      $display("ERROR: no ready within %0d cycles for %s", XFER_TIMEOUT, msg);
    end else begin
      check_latency(edges, msg);
    end
  endtask

  task automatic nmi_write(input bus_pkg::word_t addr, input bus_pkg::word_t wdata,
                           input logic [bus_pkg::STRB_W-1:0] wstrb, input string msg);
    expect_t e;
    e.is_read = 1'b0;
    e.data    = '0;
    exp_q.push_back(e);
    msg_q.push_back(msg);
    run_xfer(addr, wdata, wstrb, msg);
  endtask

  task automatic nmi_read(input bus_pkg::word_t addr, input bus_pkg::word_t expected,
                          input string msg);
    expect_t e;
    e.is_read = 1'b1;
    e.data    = expected;
    exp_q.push_back(e);
    msg_q.push_back(msg);
    run_xfer(addr, '0, '0, msg);
  endtask

  // compare process, responses are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && nmi_rsp.ready) begin
      if (exp_q.size() == 0) begin
        stray_errs++;
        $display("ERROR: ready at %0t with no transfer pending", $time);
      end else begin
        mon_exp = exp_q.pop_front();
        mon_msg = msg_q.pop_front();
        if (mon_exp.is_read) check_word(nmi_rsp.rdata, mon_exp.data, mon_msg);
      end
    end
  end

  initial begin
    void'($urandom(62359));
    data_errs  = 0;
    irq_errs   = 0;
    lat_errs   = 0;
    stray_errs = 0;
    other_errs = 0;
    rst_n      = 1'b0;
    nmi_req    = '0;
    tmr_capch  = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;

    check_irq(tmr_irq, 1'b0, "irq after reset");
    nmi_read(tmr_addr(mmap_pkg::TMR_CTRL), '0, "TMR_CTRL after reset");
    nmi_read(tmr_addr(mmap_pkg::TMR_CMP), '0, "TMR_CMP after reset");
    nmi_read(tmr_addr(mmap_pkg::TMR_CNT), '0, "TMR_CNT after reset");
    nmi_read(crc_addr(mmap_pkg::CRC_RES), '0, "CRC_RES after reset");

    for (int i = 0; i < 4; i++) begin
      pscr_sh = $urandom;
      cmp_sh  = $urandom;
      nmi_write(tmr_addr(mmap_pkg::TMR_PSCR), pscr_sh, 4'hF, "PSCR full write");
      nmi_write(tmr_addr(mmap_pkg::TMR_CMP), cmp_sh, 4'hF, "CMP full write");
      nmi_read(tmr_addr(mmap_pkg::TMR_PSCR), pscr_sh, "PSCR readback");
      nmi_read(tmr_addr(mmap_pkg::TMR_CMP), cmp_sh, "CMP readback");
    end
    // strobe of zero would turn into a read
    for (int i = 0; i < 6; i++) begin
      val  = $urandom;
      strb = 4'($urandom_range(1, 15));
      if (i % 2 == 0) begin
        pscr_sh = apply_strobe(pscr_sh, val, strb);
        nmi_write(tmr_addr(mmap_pkg::TMR_PSCR), val, strb, "PSCR strobe write");
        nmi_read(tmr_addr(mmap_pkg::TMR_PSCR), pscr_sh, "PSCR strobe readback");
      end else begin
        cmp_sh = apply_strobe(cmp_sh, val, strb);
        nmi_write(tmr_addr(mmap_pkg::TMR_CMP), val, strb, "CMP strobe write");
        nmi_read(tmr_addr(mmap_pkg::TMR_CMP), cmp_sh, "CMP strobe readback");
      end
    end

    nmi_read(slot_addr(5, mmap_pkg::TMR_PSCR), '0, "unmapped slot read");
    nmi_write(slot_addr(5, mmap_pkg::TMR_PSCR), $urandom, 4'hF, "unmapped slot write");
    nmi_read(tmr_addr(mmap_pkg::TMR_PSCR), pscr_sh, "PSCR after unmapped write");
    nmi_read(tmr_addr(mmap_pkg::TMR_CMP), cmp_sh, "CMP after unmapped write");

    nmi_write(crc_addr(mmap_pkg::CRC_CTRL), 32'h1, 4'hF, "CRC init");
    n = int'($urandom_range(1, 16));
    bytes_q.delete();
    for (int i = 0; i < n; i++) begin
      bytes_q.push_back(8'($urandom));
      nmi_write(crc_addr(mmap_pkg::CRC_DATA), {24'h0, bytes_q[i]}, 4'h1, "CRC data byte");
    end
    nmi_read(crc_addr(mmap_pkg::CRC_RES), crc32_ref(bytes_q),
             $sformatf("CRC over %0d random bytes", n));

    check_str = "123456789";
    bytes_q.delete();
    for (int i = 0; i < check_str.len(); i++) begin
      bytes_q.push_back(8'(check_str[i]));
    end
    if (crc32_ref(bytes_q) !== 32'hCBF4_3926) begin
      other_errs++;
      $display("ERROR: reference CRC disagrees with the standard check value");
    end
    nmi_write(crc_addr(mmap_pkg::CRC_CTRL), 32'h1, 4'hF, "CRC second init");
    foreach (bytes_q[i]) begin
      nmi_write(crc_addr(mmap_pkg::CRC_DATA), {24'h0, bytes_q[i]}, 4'h1, "CRC check byte");
    end
    nmi_read(crc_addr(mmap_pkg::CRC_RES), 32'hCBF4_3926, "CRC of 123456789");

    // short period so a match comes quickly
    nmi_write(tmr_addr(mmap_pkg::TMR_CTRL), 32'h0, 4'hF, "timer off");
    pscr_sh = 32'd3;
    cmp_sh  = 32'd4;
    nmi_write(tmr_addr(mmap_pkg::TMR_PSCR), pscr_sh, 4'hF, "PSCR small");
    nmi_write(tmr_addr(mmap_pkg::TMR_CMP), cmp_sh, 4'hF, "CMP small");
    nmi_write(tmr_addr(mmap_pkg::TMR_CNT), 32'h0, 4'hF, "CNT clear");
    nmi_write(tmr_addr(mmap_pkg::TMR_STAT), 32'h1, 4'hF, "STAT clear");
    nmi_write(tmr_addr(mmap_pkg::TMR_CTRL), 32'h3, 4'hF, "timer and irq on");
    cycles = 0;
    while (!tmr_irq && cycles < IRQ_TIMEOUT) begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (!tmr_irq) begin
      other_errs++;
      $display("ERROR: timer interrupt did not rise within %0d cycles", IRQ_TIMEOUT);
    end
    // stop the counter, keep the interrupt enable
    nmi_write(tmr_addr(mmap_pkg::TMR_CTRL), 32'h2, 4'hF, "timer stop");
    check_irq(tmr_irq, 1'b1, "irq while flag set");
    nmi_read(tmr_addr(mmap_pkg::TMR_STAT), 32'h1, "STAT match flag");
    nmi_write(tmr_addr(mmap_pkg::TMR_STAT), 32'h1, 4'hF, "STAT write one");
    check_irq(tmr_irq, 1'b0, "irq after STAT clear");
    nmi_read(tmr_addr(mmap_pkg::TMR_STAT), 32'h0, "STAT after clear");

    nmi_write(tmr_addr(mmap_pkg::TMR_CNT), 32'h0, 4'hF, "CNT clear again");
    nmi_write(tmr_addr(mmap_pkg::TMR_CTRL), 32'h1, 4'hF, "timer on, irq off");
    // covers more than two full compare periods
    repeat (60) begin
      @(posedge clk);
      #10;
      check_irq(tmr_irq, 1'b0, "irq with enable cleared");
    end
    nmi_write(tmr_addr(mmap_pkg::TMR_CTRL), 32'h0, 4'hF, "timer off again");
    nmi_read(tmr_addr(mmap_pkg::TMR_STAT), 32'h1, "STAT flag without irq enable");

    val = $urandom;
    nmi_write(tmr_addr(mmap_pkg::TMR_CNT), val, 4'hF, "CNT load for capture");
    tmr_capch = 1'b1;
    wait_cycles(2);
    tmr_capch = 1'b0;
    wait_cycles(6);
    nmi_read(tmr_addr(mmap_pkg::TMR_CAP), val, "CAP after capture pulse");

    wait_cycles(2);
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("ERROR: %0d transfers never completed", exp_q.size());
    end
    $display("errors: data=%0d irq=%0d latency=%0d stray=%0d other=%0d",
             data_errs, irq_errs, lat_errs, stray_errs, other_errs);
    if (data_errs + irq_errs + lat_errs + stray_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
bus_pkg.sv
mmap_pkg.sv
crc32_core.sv
apb4_crc_regs.sv
apb4_tmr.sv
nmi2apb.sv
ip_apb_wrapper.sv
tb_ip_apb_wrapper.sv

// File: Makefile
# Verilator flow for the APB peripheral island
TOP = tb_ip_apb_wrapper

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
